//--- common/mpu_pkg.sv
/*
  Shared definitions for the data-side MPU.
  The PMA table is fixed at build time and holds 1 to 16 regions.
  Region bounds are word addresses and the high bound is exclusive,
  so the last word of the 4 GiB space cannot be covered by a region.
  Main regions must also be atomic and I/O regions must not be cacheable.
*/
package mpu_pkg;

  localparam int ADDR_W        = 32;
  localparam int DATA_W        = 32;
  // Counter width, at most 3 bus transactions in flight
  localparam int OUTSTANDING_W = 2;

  // One PMA region, 64 bits
  typedef struct packed {
    logic [29:0] word_addr_low;
    logic [29:0] word_addr_high;
    logic        main;
    logic        bufferable;
    logic        cacheable;
    logic        atomic;
  } pma_region_t;

  localparam int PMA_NUM_REGIONS = 4;

  // Regions 0 and 1 overlap in 0x0000_8000 .. 0x0000_FFFF, region 0 wins there
  localparam pma_region_t PMA_CFG [PMA_NUM_REGIONS] = '{
    // 0x0000_0000 .. 0x0000_FFFF main RAM
    '{word_addr_low: 30'h0000_0000, word_addr_high: 30'h0000_4000,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b1, atomic: 1'b1},
    // 0x0000_8000 .. 0x0001_FFFF main, uncached
    '{word_addr_low: 30'h0000_2000, word_addr_high: 30'h0000_8000,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b0, atomic: 1'b1},
    // 0x1000_0000 .. 0x1000_0FFF strongly ordered I/O
    '{word_addr_low: 30'h0400_0000, word_addr_high: 30'h0400_0400,
      main: 1'b0, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b0},
    // 0x2000_0000 .. 0x2000_FFFF bufferable I/O
    '{word_addr_low: 30'h0800_0000, word_addr_high: 30'h0800_4000,
      main: 1'b0, bufferable: 1'b1, cacheable: 1'b0, atomic: 1'b0}
  };

  // Attributes for an address outside every region
  localparam pma_region_t PMA_R_DEFAULT = '0;

  typedef enum logic [1:0] {
    MPU_IDLE,
    MPU_WAIT_DRAIN,
    MPU_ERR_RESP
  } mpu_state_e;

  typedef enum logic [1:0] {
    MPU_OK,
    MPU_ERR_EXEC,
    MPU_ERR_ATOMIC
  } mpu_status_e;

endpackage

//--- hw/pma/pma_lookup.sv
/*
  PMA region lookup and access permission check, purely combinational.
  The lowest-index region that contains the address wins.
  Execute on a non-main region is refused first, then atomic on a
  region without atomic support. clk and rst_n only feed the checks.
*/
`timescale 1ns/1ps

module pma_lookup (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [mpu_pkg::ADDR_W-1:0]     addr_i,
  input  logic                           execute_i,
  input  logic                           atomic_i,
  output mpu_pkg::pma_region_t           region_o,
  output logic                           pma_err_o,
  output mpu_pkg::mpu_status_e           err_status_o
);

  logic                 region_hit;
  mpu_pkg::pma_region_t region_sel;
  mpu_pkg::mpu_status_e status;

  //////////////////////////////
  // Region search
  //////////////////////////////

  always_comb begin
    region_hit = 1'b0;
    region_sel = mpu_pkg::PMA_R_DEFAULT;
    for (int i = 0; i < mpu_pkg::PMA_NUM_REGIONS; i++) begin
      // First hit sticks, later regions are ignored
      if (!region_hit &&
          ({mpu_pkg::PMA_CFG[i].word_addr_low, 2'b00} <= addr_i) &&
          (addr_i < {mpu_pkg::PMA_CFG[i].word_addr_high, 2'b00})) begin
        region_hit = 1'b1;
        region_sel = mpu_pkg::PMA_CFG[i];
      end
    end
  end

  //////////////////////////////
  // Permission check
  //////////////////////////////

  always_comb begin
    status = mpu_pkg::MPU_OK;
    if (execute_i && !region_sel.main) begin
      status = mpu_pkg::MPU_ERR_EXEC;
    end else if (atomic_i && !region_sel.atomic) begin
      status = mpu_pkg::MPU_ERR_ATOMIC;
    end
  end

  assign region_o     = region_sel;
  assign err_status_o = status;
  assign pma_err_o    = (status != mpu_pkg::MPU_OK);

  // Selected region really contains the address
  a_region_bounds :
    assert property (@(posedge clk) disable iff (!rst_n)
                     region_hit |->
                       (({region_o.word_addr_low, 2'b00} <= addr_i) &&
                        (addr_i < {region_o.word_addr_high, 2'b00})))
      else $error("pma_lookup: selected region does not contain address");

  // Error flag follows the attribute rule on the selected region
  a_err_rule :
    assert property (@(posedge clk) disable iff (!rst_n)
                     pma_err_o == ((execute_i && !region_o.main) ||
                                   (atomic_i && !region_o.atomic)))
      else $error("pma_lookup: error flag disagrees with region attributes");

endmodule

//--- hw/mpu/mpu_ctrl.sv
/*
  MPU control: steers each core transfer to the bus or to the error path.
  A refused transfer is accepted at once, then the FSM waits for all
  outstanding bus responses and sends a single error response.
  Only one error can be pending. With 3 transfers in flight the core is
  back-pressured until a response returns.
*/
`timescale 1ns/1ps

module mpu_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           core_trans_valid_i,
  input  logic                           pma_err_i,
  input  mpu_pkg::mpu_status_e           err_status_i,
  input  logic                           bus_trans_ready_i,
  input  logic                           obi_rvalid_i,
  input  logic [mpu_pkg::DATA_W-1:0]     obi_rdata_i,
  output logic                           core_trans_ready_o,
  output logic                           bus_trans_valid_o,
  output logic                           core_resp_valid_o,
  output logic [mpu_pkg::DATA_W-1:0]     core_resp_rdata_o,
  output mpu_pkg::mpu_status_e           core_resp_status_o
);

  mpu_pkg::mpu_state_e              state_q;
  mpu_pkg::mpu_state_e              state_d;
  mpu_pkg::mpu_status_e             err_status_q;
  mpu_pkg::mpu_status_e             err_status_d;
  logic [mpu_pkg::OUTSTANDING_W-1:0] outstanding_q;
  logic [mpu_pkg::OUTSTANDING_W-1:0] outstanding_d;
  logic                              cnt_full;
  logic                              bus_hs;
  logic                              err_resp;
  logic                              drain_done;

  assign cnt_full = &outstanding_q;
  assign bus_hs   = bus_trans_valid_o && bus_trans_ready_i;
  assign err_resp = (state_q == mpu_pkg::MPU_ERR_RESP);

  // All earlier bus responses are back by the end of this cycle
  assign drain_done = (outstanding_q == '0) ||
                      (obi_rvalid_i && ((outstanding_q - 1'b1) == '0));

  //////////////////////////////
  // Outstanding counter
  //////////////////////////////

  always_comb begin
    outstanding_d = outstanding_q;
    if (bus_hs && !obi_rvalid_i) begin
      outstanding_d = outstanding_q + 1'b1;
    end else if (!bus_hs && obi_rvalid_i) begin
      outstanding_d = outstanding_q - 1'b1;
    end
  end

  //////////////////////////////
  // Transfer steering and FSM
  //////////////////////////////

  always_comb begin
    state_d            = state_q;
    err_status_d       = err_status_q;
    core_trans_ready_o = 1'b0;
    bus_trans_valid_o  = 1'b0;

    case (state_q)
      mpu_pkg::MPU_IDLE: begin
        if (core_trans_valid_i && !cnt_full) begin
          if (pma_err_i) begin
            // Swallow the transfer, the bus never sees it
            core_trans_ready_o = 1'b1;
            err_status_d       = err_status_i;
            state_d            = drain_done ? mpu_pkg::MPU_ERR_RESP
                                            : mpu_pkg::MPU_WAIT_DRAIN;
          end else begin
            bus_trans_valid_o  = 1'b1;
            core_trans_ready_o = bus_trans_ready_i;
          end
        end
      end

      mpu_pkg::MPU_WAIT_DRAIN: begin
        if (drain_done) begin
          state_d = mpu_pkg::MPU_ERR_RESP;
        end
      end

      mpu_pkg::MPU_ERR_RESP: begin
        state_d = mpu_pkg::MPU_IDLE;
      end

      default: begin
        state_d = mpu_pkg::MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= mpu_pkg::MPU_IDLE;
      err_status_q  <= mpu_pkg::MPU_OK;
      outstanding_q <= '0;
    end else begin
      state_q       <= state_d;
      err_status_q  <= err_status_d;
      outstanding_q <= outstanding_d;
    end
  end

  // Bus and error responses never collide, so a plain merge is enough
  assign core_resp_valid_o  = obi_rvalid_i || err_resp;
  assign core_resp_rdata_o  = err_resp ? '0 : obi_rdata_i;
  assign core_resp_status_o = err_resp ? err_status_q : mpu_pkg::MPU_OK;

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_no_resp_collision :
    assert property (@(posedge clk) disable iff (!rst_n)
                     !(obi_rvalid_i && err_resp))
      else $error("mpu_ctrl: bus response during error response");

  // Error status exactly in the error response cycle
  a_status_in_err_resp :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (core_resp_status_o != mpu_pkg::MPU_OK) == err_resp)
      else $error("mpu_ctrl: error status outside error response");

  a_block_core :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (state_q != mpu_pkg::MPU_IDLE) |-> !core_trans_ready_o)
      else $error("mpu_ctrl: core accepted while error pending");

  // Every rvalid must belong to a granted request
  a_no_underflow :
    assert property (@(posedge clk) disable iff (!rst_n)
                     obi_rvalid_i |-> (outstanding_q != '0))
      else $error("mpu_ctrl: response without outstanding request");

endmodule

//--- hw/obi_req_stage.sv
/*
  OBI request stage. The request follows bus_trans_valid_i with no delay.
  Once a request waits for a grant, address and memtype come from a
  local copy so they stay stable on the bus.
  Assumes the upstream keeps valid high until the grant arrives.
*/
`timescale 1ns/1ps

module obi_req_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           bus_trans_valid_i,
  input  logic [mpu_pkg::ADDR_W-1:0]     addr_i,
  input  logic                           bufferable_i,
  input  logic                           cacheable_i,
  output logic                           bus_trans_ready_o,
  output logic                           obi_req_o,
  output logic [mpu_pkg::ADDR_W-1:0]     obi_addr_o,
  output logic [1:0]                     obi_memtype_o,
  input  logic                           obi_gnt_i
);

  logic                       wait_q;
  logic [mpu_pkg::ADDR_W-1:0] addr_q;
  logic [1:0]                 memtype_q;
  logic [1:0]                 memtype_in;

  // Bit 1 cacheable, bit 0 bufferable
  assign memtype_in = {cacheable_i, bufferable_i};

  assign obi_req_o         = bus_trans_valid_i;
  assign obi_addr_o        = wait_q ? addr_q : addr_i;
  assign obi_memtype_o     = wait_q ? memtype_q : memtype_in;
  assign bus_trans_ready_o = obi_gnt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= obi_req_o && !obi_gnt_i;
    end
  end

  // Hold copy, refreshed only while a request is on the bus
  always_ff @(posedge clk) begin
    if (obi_req_o && !obi_gnt_i) begin
      addr_q    <= obi_addr_o;
      memtype_q <= obi_memtype_o;
    end
  end

  a_req_stable :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (obi_req_o && !obi_gnt_i) |=>
                       (obi_req_o && $stable(obi_addr_o) && $stable(obi_memtype_o)))
      else $error("obi_req_stage: request changed while waiting for grant");

endmodule

//--- hw/data_mpu_top.sv
/*
  Data-side MPU between the core load/store port and an OBI-like bus.
  Address only, no write data or byte enables.
  Allowed transfers pass with zero latency, refused ones get an error
  response after all earlier bus responses.
*/
`timescale 1ns/1ps

module data_mpu_top (
  input  logic                           clk,
  input  logic                           rst_n,

  // Core side
  input  logic                           core_trans_valid_i,
  input  logic [mpu_pkg::ADDR_W-1:0]     core_addr_i,
  input  logic                           core_execute_i,
  input  logic                           core_atomic_i,
  output logic                           core_trans_ready_o,
  output logic                           core_resp_valid_o,
  output logic [mpu_pkg::DATA_W-1:0]     core_resp_rdata_o,
  output mpu_pkg::mpu_status_e           core_resp_status_o,

  // Bus side
  output logic                           obi_req_o,
  output logic [mpu_pkg::ADDR_W-1:0]     obi_addr_o,
  output logic [1:0]                     obi_memtype_o,
  input  logic                           obi_gnt_i,
  input  logic                           obi_rvalid_i,
  input  logic [mpu_pkg::DATA_W-1:0]     obi_rdata_i
);

  mpu_pkg::pma_region_t region;
  mpu_pkg::mpu_status_e err_status;
  logic                 pma_err;
  logic                 bus_trans_valid;
  logic                 bus_trans_ready;

  pma_lookup u_pma_lookup (
    .clk          (clk),
    .rst_n        (rst_n),
    .addr_i       (core_addr_i),
    .execute_i    (core_execute_i),
    .atomic_i     (core_atomic_i),
    .region_o     (region),
    .pma_err_o    (pma_err),
    .err_status_o (err_status)
  );

  mpu_ctrl u_mpu_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_trans_valid_i (core_trans_valid_i),
    .pma_err_i          (pma_err),
    .err_status_i       (err_status),
    .bus_trans_ready_i  (bus_trans_ready),
    .obi_rvalid_i       (obi_rvalid_i),
    .obi_rdata_i        (obi_rdata_i),
    .core_trans_ready_o (core_trans_ready_o),
    .bus_trans_valid_o  (bus_trans_valid),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_rdata_o  (core_resp_rdata_o),
    .core_resp_status_o (core_resp_status_o)
  );

  obi_req_stage u_obi_req_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .bus_trans_valid_i (bus_trans_valid),
    .addr_i            (core_addr_i),
    .bufferable_i      (region.bufferable),
    .cacheable_i       (region.cacheable),
    .bus_trans_ready_o (bus_trans_ready),
    .obi_req_o         (obi_req_o),
    .obi_addr_o        (obi_addr_o),
    .obi_memtype_o     (obi_memtype_o),
    .obi_gnt_i         (obi_gnt_i)
  );

endmodule

//--- bench/tb_data_mpu.sv
/*
  Random testbench for the data-side MPU.
  A core driver, an OBI responder and an in-order reference model run together.
  Grants come after 0 to 3 wait cycles. Read data returns 1 to 4 cycles after
  the grant and is mixed from the address. The run stops at the first error.
*/
`timescale 1ns/1ps

module tb_data_mpu;

  localparam int NUM_TRANS = 400;
  localparam int TIMEOUT   = 200;

  logic                 clk;
  logic                 rst_n;
  logic                 core_trans_valid_i;
  logic [31:0]          core_addr_i;
  logic                 core_execute_i;
  logic                 core_atomic_i;
  logic                 core_trans_ready_o;
  logic                 core_resp_valid_o;
  logic [31:0]          core_resp_rdata_o;
  mpu_pkg::mpu_status_e core_resp_status_o;
  logic                 obi_req_o;
  logic [31:0]          obi_addr_o;
  logic [1:0]           obi_memtype_o;
  logic                 obi_gnt_i;
  logic                 obi_rvalid_i;
  logic [31:0]          obi_rdata_i;

  integer               seed;
  int                   cyc;
  logic [1:0]           gnt_wait;
  logic                 denied_pend;
  logic                 prev_wait;
  logic [31:0]          prev_addr;
  logic [1:0]           prev_mt;
  logic [31:0]          rsp_addr_q[$];
  int                   rsp_due_q[$];
  mpu_pkg::mpu_status_e exp_status_q[$];
  logic [31:0]          exp_data_q[$];

  data_mpu_top u_data_mpu_top (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_trans_valid_i (core_trans_valid_i),
    .core_addr_i        (core_addr_i),
    .core_execute_i     (core_execute_i),
    .core_atomic_i      (core_atomic_i),
    .core_trans_ready_o (core_trans_ready_o),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_rdata_o  (core_resp_rdata_o),
    .core_resp_status_o (core_resp_status_o),
    .obi_req_o          (obi_req_o),
    .obi_addr_o         (obi_addr_o),
    .obi_memtype_o      (obi_memtype_o),
    .obi_gnt_i          (obi_gnt_i),
    .obi_rvalid_i       (obi_rvalid_i),
    .obi_rdata_i        (obi_rdata_i)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Scan from the top so the lowest matching index is the one left standing
  function automatic mpu_pkg::pma_region_t model_region(input logic [31:0] addr);
    model_region = mpu_pkg::PMA_R_DEFAULT;
    for (int i = mpu_pkg::PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (addr[31:2] >= mpu_pkg::PMA_CFG[i].word_addr_low &&
          addr[31:2] < mpu_pkg::PMA_CFG[i].word_addr_high) begin
        model_region = mpu_pkg::PMA_CFG[i];
      end
    end
  endfunction

  function automatic mpu_pkg::mpu_status_e model_status(input logic [31:0] addr,
                                                        input logic exe,
                                                        input logic atom);
    mpu_pkg::pma_region_t reg_m;
    reg_m = model_region(addr);
    if (exe && !reg_m.main) begin
      model_status = mpu_pkg::MPU_ERR_EXEC;
    end else if (atom && !reg_m.atomic) begin
      model_status = mpu_pkg::MPU_ERR_ATOMIC;
    end else begin
      model_status = mpu_pkg::MPU_OK;
    end
  endfunction

  // Read data the responder returns for an address
  function automatic logic [31:0] mix_data(input logic [31:0] addr);
    mix_data = {addr[15:0], addr[31:16]} ^ 32'ha5c3_3c5a;
  endfunction

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic stop_failed();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at %0t ns", $time);
  endtask

  task automatic check_status(input mpu_pkg::mpu_status_e got,
                              input mpu_pkg::mpu_status_e exp);
    if (got !== exp) begin
      $display("MISMATCH core_resp_status_o got 0x%h expected 0x%h", got, exp);
      stop_failed();
    end
  endtask

  task automatic check_data(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH core_resp_rdata_o got 0x%08h expected 0x%08h", got, exp);
      stop_failed();
    end
  endtask

  task automatic check_memtype(input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH obi_memtype_o got 0x%h expected 0x%h", got, exp);
      stop_failed();
    end
  endtask

  task automatic check_addr(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH obi_addr_o got 0x%08h expected 0x%08h", got, exp);
      stop_failed();
    end
  endtask

  // Single-bit control outputs
  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_idle_outputs();
    check_flag("obi_req_o", obi_req_o, 1'b0);
    check_flag("core_trans_ready_o", core_trans_ready_o, 1'b0);
    check_flag("core_resp_valid_o", core_resp_valid_o, 1'b0);
  endtask

  //////////////////////////////
  // Bus responder
  //////////////////////////////

  initial begin
    cyc = 0;
    obi_gnt_i    <= 1'b0;
    obi_rvalid_i <= 1'b0;
    obi_rdata_i  <= '0;
    forever begin
      @(posedge clk);
      cyc = cyc + 1;
      if (!rst_n) begin
        obi_gnt_i    <= 1'b0;
        obi_rvalid_i <= 1'b0;
      end else begin
        obi_gnt_i <= (gnt_wait == 2'd0);
        if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
          obi_rvalid_i <= 1'b1;
          obi_rdata_i  <= mix_data(rsp_addr_q.pop_front());
          void'(rsp_due_q.pop_front());
        end else begin
          obi_rvalid_i <= 1'b0;
        end
      end
    end
  end

  // Monitor at the falling edge, where inputs and outputs have settled
  always @(negedge clk) begin
    mpu_pkg::pma_region_t exp_reg;
    mpu_pkg::mpu_status_e exp_st;
    logic [31:0]          rnd;
    if (!rst_n) begin
      gnt_wait    = 2'd0;
      denied_pend = 1'b0;
      prev_wait   = 1'b0;
    end else begin
      exp_reg = model_region(core_addr_i);
      exp_st  = model_status(core_addr_i, core_execute_i, core_atomic_i);

      // Held request must not move
      if (prev_wait) begin
        check_flag("obi_req_o", obi_req_o, 1'b1);
        check_addr(obi_addr_o, prev_addr);
        check_memtype(obi_memtype_o, prev_mt);
      end
      prev_wait = obi_req_o && !obi_gnt_i;
      prev_addr = obi_addr_o;
      prev_mt   = obi_memtype_o;

      // Nothing passes while an error response is pending
      if (denied_pend && core_trans_valid_i) begin
        check_flag("core_trans_ready_o", core_trans_ready_o, 1'b0);
        check_flag("obi_req_o", obi_req_o, 1'b0);
      end

      if (obi_req_o && exp_st != mpu_pkg::MPU_OK) begin
        $display("Bus request raised for denied access to 0x%08h", core_addr_i);
        stop_failed();
      end else if (obi_req_o) begin
        check_addr(obi_addr_o, core_addr_i);
        check_memtype(obi_memtype_o, {exp_reg.cacheable, exp_reg.bufferable});
        check_flag("core_trans_ready_o", core_trans_ready_o, obi_gnt_i);
        if (obi_gnt_i) begin
          rnd = $random(seed);
          rsp_addr_q.push_back(obi_addr_o);
          rsp_due_q.push_back(cyc + 1 + int'(rnd[3:2]));
          gnt_wait = rnd[1:0];
        end else if (gnt_wait != 2'd0) begin
          gnt_wait = gnt_wait - 2'd1;
        end
      end

      if (core_trans_valid_i && core_trans_ready_o) begin
        exp_status_q.push_back(exp_st);
        exp_data_q.push_back(mix_data(core_addr_i));
        if (exp_st != mpu_pkg::MPU_OK) begin
          denied_pend = 1'b1;
        end
      end

      // Bus responses reach the core in the same cycle
      if (obi_rvalid_i) begin
        check_flag("core_resp_valid_o", core_resp_valid_o, 1'b1);
      end

      if (core_resp_valid_o && exp_status_q.size() == 0) begin
        $display("Core response seen with no transfer outstanding");
        stop_failed();
      end else if (core_resp_valid_o) begin
        check_status(core_resp_status_o, exp_status_q[0]);
        if (exp_status_q[0] == mpu_pkg::MPU_OK) begin
          check_data(core_resp_rdata_o, exp_data_q[0]);
        end else begin
          denied_pend = 1'b0;
        end
        void'(exp_status_q.pop_front());
        void'(exp_data_q.pop_front());
      end
    end
  end

  //////////////////////////////
  // Core driver
  //////////////////////////////

  // Address classes: each region, the 0/1 overlap, two gaps, above all regions
  task automatic pick_stimulus(output logic [31:0] addr, output logic exe,
                               output logic atom);
    logic [31:0]          sel;
    logic [31:0]          r;
    logic [29:0]          span;
    mpu_pkg::pma_region_t reg_c;
    sel  = $random(seed);
    r    = $random(seed);
    exe  = sel[3] & sel[4];
    atom = sel[5] & sel[6];
    case (sel[2:0])
      3'd0, 3'd1, 3'd2, 3'd3: begin
        reg_c = mpu_pkg::PMA_CFG[sel[1:0]];
        span  = reg_c.word_addr_high - reg_c.word_addr_low;
        addr  = {reg_c.word_addr_low + (r[29:0] % span), r[31:30]};
      end
      3'd4: addr = {16'h0000, 1'b1, r[14:0]};
      3'd5: addr = {5'b00001, r[26:0]};
      3'd6: addr = {8'h11, r[23:0]};
      default: addr = {2'b11, r[29:0]};
    endcase
  endtask

  task automatic wait_accept();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!(core_trans_valid_i && core_trans_ready_o)) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        $display("Transfer to 0x%08h not accepted within %0d cycles", core_addr_i, TIMEOUT);
        stop_failed();
      end else begin
        @(negedge clk);
      end
    end
    @(posedge clk);
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    @(posedge clk);
    while (exp_status_q.size() != 0) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        $display("%0d responses still missing after %0d cycles", exp_status_q.size(), TIMEOUT);
        stop_failed();
      end else begin
        @(posedge clk);
      end
    end
  endtask

  initial begin
    logic [31:0] a;
    logic        e;
    logic        t;
    logic [31:0] r;
    int          n;
    seed = 32'h656e;
    clk  = 1'b0;
    rst_n              <= 1'b0;
    core_trans_valid_i <= 1'b0;
    core_addr_i        <= '0;
    core_execute_i     <= 1'b0;
    core_atomic_i      <= 1'b0;

    @(posedge clk);
    @(negedge clk);
    check_idle_outputs();
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_idle_outputs();
    @(posedge clk);

    for (n = 0; n < NUM_TRANS; n++) begin
      pick_stimulus(a, e, t);
      core_trans_valid_i <= 1'b1;
      core_addr_i        <= a;
      core_execute_i     <= e;
      core_atomic_i      <= t;
      wait_accept();
      r = $random(seed);
      // Occasional idle cycles between transfers
      if (r[1:0] == 2'd0) begin
        core_trans_valid_i <= 1'b0;
        repeat (int'(r[3:2]) + 1) @(posedge clk);
      end
    end
    core_trans_valid_i <= 1'b0;
    wait_drain();

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- sources.f
common/mpu_pkg.sv
hw/pma/pma_lookup.sv
hw/mpu/mpu_ctrl.sv
hw/obi_req_stage.sv
hw/data_mpu_top.sv
bench/tb_data_mpu.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_data_mpu
RTL_TOP    := data_mpu_top
FILELIST   := sources.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
